// File: tb.f
+incdir+include
hw/cache_be_pkg.sv
hw/cache_read_channel.sv
hw/cache_write_channel.sv
hw/cache_back_end.sv
verification/be_mem_model.sv
verification/cache_back_end_asserts.sv
verification/tb_cache_back_end.sv

// File: run_sim.sh
#!/bin/sh
# builds the cache back end testbench with Verilator and runs it into sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f tb.f \
   --top-module tb_cache_back_end

./obj_dir/Vtb_cache_back_end > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "simulation reported failure, see sim.log"
   exit 1
fi

echo "simulation finished without failure"
exit 0

// File: verification/tb_cache_back_end.sv
// directed testbench for the cache back end
// memory model answers the bus, a mirror array holds the expected memory
`timescale 1ns/1ps
`default_nettype none

module tb_cache_back_end
   import cache_be_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   localparam int MEM_WORDS  = 256;
   // six tests need a few hundred cycles even with long stalls
   localparam int TIMEOUT_CYCLES = 5000;

   logic       clk_i = 1'b0;
   logic       arst_n_i;
   logic       write_valid_i;
   word_addr_t write_addr_i;
   word_t      write_wdata_i;
   wstrb_t     write_wstrb_i;
   logic       write_ready_o;
   logic       replace_valid_i;
   line_addr_t replace_addr_i;
   logic       replace_o;
   logic       read_valid_o;
   word_off_t  read_addr_o;
   word_t      read_rdata_o;
   logic       iob_valid_o;
   be_addr_t   iob_addr_o;
   word_t      iob_wdata_o;
   wstrb_t     iob_wstrb_o;
   word_t      iob_rdata_i;
   logic       iob_rvalid_i;
   logic       iob_ready_i;

   word_t       mirror [MEM_WORDS];
   word_t       got_words [4];
   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          cycle_cnt = 0;

   cache_back_end dut (.*);

   be_mem_model u_mem (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .iob_valid_i (iob_valid_o),
      .iob_addr_i  (iob_addr_o),
      .iob_wdata_i (iob_wdata_o),
      .iob_wstrb_i (iob_wstrb_o),
      .iob_rdata_o (iob_rdata_i),
      .iob_rvalid_o(iob_rvalid_i),
      .iob_ready_o (iob_ready_i)
   );

   bind cache_back_end cache_back_end_asserts u_asserts (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .bus_valid_i(iob_valid_o),
      .bus_addr_i (iob_addr_o),
      .bus_wdata_i(iob_wdata_o),
      .bus_wstrb_i(iob_wstrb_o),
      .bus_ready_i(iob_ready_i),
      .refill_i   (replace_o),
      .rd_valid_i (read_valid_o)
   );

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   task automatic report_and_stop(input bit timed_out);
      $display("tb done: %0d checks, %0d errors", chk_cnt, err_cnt + int'(timed_out));
      if (err_cnt == 0 && !timed_out) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   endtask

   // hard stop for a test that waits forever
   always @(posedge clk_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("timeout: no progress after %0d cycles", cycle_cnt);
         report_and_stop(1'b1);
      end
   end

   task automatic check_word(input string name, input word_t got, input word_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   // expected memory, byte lanes under the strobes
   function automatic void mirror_write(input logic [7:0] idx, input word_t data,
                                        input wstrb_t strb);
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            mirror[idx][8*b +: 8] = data[8*b +: 8];
         end
      end
   endfunction

   // hold the request until the write buffer handshake
   task automatic issue_write(input word_addr_t addr, input word_t data, input wstrb_t strb);
      @(posedge clk_i);
      #1;
      write_valid_i = 1'b1;
      write_addr_i  = addr;
      write_wdata_i = data;
      write_wstrb_i = strb;
      @(negedge clk_i);
      while (!write_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      write_valid_i = 1'b0;
      mirror_write(addr[7:0], data, strb);
   endtask

   task automatic wait_write_idle;
      @(negedge clk_i);
      while (!write_ready_o) @(negedge clk_i);
   endtask

   // one refill, every returned word checked against the mirror
   task automatic run_refill(input line_addr_t line);
      int nwords;
      bit seen_busy;
      bit ready_seen;
      nwords     = 0;
      seen_busy  = 1'b0;
      ready_seen = 1'b0;
      @(posedge clk_i);
      #1;
      replace_valid_i = 1'b1;
      replace_addr_i  = line;
      while (!(seen_busy && !replace_o)) begin
         @(negedge clk_i);
         // refill ends in the cycle after the last word
         if (nwords == 4) begin
            check_bit("replace_o", replace_o, 1'b0);
         end
         if (write_ready_o) begin
            ready_seen = 1'b1;
         end
         if (read_valid_o) begin
            if (!ready_seen) begin
               err_cnt++;
               $display("t=%0t refill word returned before the pending write ended", $time);
            end
            if (nwords < 4) begin
               check_word("read_addr_o", word_t'(read_addr_o), word_t'(nwords));
               check_word("read_rdata_o", read_rdata_o,
                          mirror[{line[5:0], word_off_t'(nwords)}]);
               got_words[nwords] = read_rdata_o;
            end
            nwords++;
         end
         // refill running, request can go
         if (replace_o && !seen_busy) begin
            seen_busy = 1'b1;
            @(posedge clk_i);
            #1;
            replace_valid_i = 1'b0;
         end
      end
      check_word("refill word count", word_t'(nwords), 32'd4);
   endtask

   task automatic compare_memory;
      for (int i = 0; i < MEM_WORDS; i++) begin
         check_word($sformatf("mem[%0d]", i), u_mem.mem[i], mirror[i]);
      end
   endtask

   task automatic reset_values;
      @(negedge clk_i);
      check_bit("iob_valid_o", iob_valid_o, 1'b0);
      check_bit("replace_o", replace_o, 1'b0);
      check_bit("read_valid_o", read_valid_o, 1'b0);
      check_bit("write_ready_o", write_ready_o, 1'b1);
   endtask

   task automatic single_write;
      issue_write(word_addr_t'(8'h13), 32'hDEAD_BEEF, 4'hF);
      // write still in flight, no new write taken
      @(negedge clk_i);
      check_bit("write_ready_o", write_ready_o, 1'b0);
      wait_write_idle();
      check_word("mem[19]", u_mem.mem[8'h13], 32'hDEAD_BEEF);
      check_word("mem[19] mirror", u_mem.mem[8'h13], mirror[8'h13]);
   endtask

   task automatic line_refill;
      run_refill(line_addr_t'(6'h05));
   endtask

   // bytes 0 and 2 new, bytes 1 and 3 old
   task automatic partial_write_refill;
      word_t old_w;
      word_t new_w;
      word_t exp_w;
      old_w = mirror[8'h22];
      new_w = 32'h1122_3344;
      exp_w = {old_w[31:24], new_w[23:16], old_w[15:8], new_w[7:0]};
      issue_write(word_addr_t'(8'h22), new_w, 4'b0101);
      wait_write_idle();
      run_refill(line_addr_t'(6'h08));
      check_word("merged refill word", got_words[2], exp_w);
   endtask

   task automatic write_burst;
      logic [31:0] r_addr;
      logic [31:0] r_data;
      logic [31:0] r_strb;
      wstrb_t      strb;
      for (int n = 0; n < 8; n++) begin
         r_addr = $urandom;
         r_data = $urandom;
         r_strb = $urandom;
         strb   = r_strb[3:0];
         if (strb == 4'h0) begin
            strb = 4'hF;
         end
         issue_write(word_addr_t'(r_addr[7:0]), r_data, strb);
      end
      wait_write_idle();
      compare_memory();
   endtask

   // refill raised while the write is still on the bus
   task automatic refill_during_write;
      issue_write(word_addr_t'(8'h46), 32'hCAFE_0123, 4'b1100);
      run_refill(line_addr_t'(6'h11));
      check_word("refill word upper half", {16'h0000, got_words[2][31:16]}, 32'h0000_CAFE);
   endtask

   initial begin
      void'($urandom(32'h3fae_fa31));
      arst_n_i        = 1'b0;
      write_valid_i   = 1'b0;
      write_addr_i    = '0;
      write_wdata_i   = '0;
      write_wstrb_i   = '0;
      replace_valid_i = 1'b0;
      replace_addr_i  = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mirror[i] = word_t'(i) ^ 32'hA5A5_0000;
      end
      repeat (10) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      reset_values();
      single_write();
      line_refill();
      partial_write_refill();
      write_burst();
      refill_during_write();
      report_and_stop(1'b0);
   end

endmodule

`default_nettype wire

// File: verification/cache_back_end_asserts.sv
// bus protocol properties of the cache back end
// bound to the top level from the testbench
`timescale 1ns/1ps
`default_nettype none

module cache_back_end_asserts
   import cache_be_pkg::*;
(
   input logic     clk_i,
   input logic     arst_n_i,
   input logic     bus_valid_i,
   input be_addr_t bus_addr_i,
   input word_t    bus_wdata_i,
   input wstrb_t   bus_wstrb_i,
   input logic     bus_ready_i,
   input logic     refill_i,
   input logic     rd_valid_i
);

   // request held unchanged while the bus stalls
   req_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (bus_valid_i && !bus_ready_i) |=>
         (bus_valid_i && $stable(bus_addr_i) && $stable(bus_wstrb_i) && $stable(bus_wdata_i)))
      else $error("bus request changed while stalled");

   // returned words only inside a refill, no other request on the bus meanwhile
   rd_in_refill_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_valid_i |-> (refill_i && !bus_valid_i))
      else $error("read_valid_o outside a refill or with a request on the bus");

   // refill traffic is reads only
   no_write_in_refill_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      refill_i |-> (bus_wstrb_i == '0))
      else $error("write strobes during a refill");

   // bus quiet in reset
   reset_quiet_a: assert property (@(posedge clk_i) !arst_n_i |-> !bus_valid_i)
      else $error("iob_valid_o high during reset");

endmodule

`default_nettype wire

// File: verification/be_mem_model.sv
// behavioral memory on the native bus of the cache back end
// random ready stalls, reads answered 1 to 4 cycles after the accept
`timescale 1ns/1ps
`default_nettype none

module be_mem_model
   import cache_be_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     iob_valid_i,
   input  be_addr_t iob_addr_i,
   input  word_t    iob_wdata_i,
   input  wstrb_t   iob_wstrb_i,
   output word_t    iob_rdata_o,
   output logic     iob_rvalid_o,
   output logic     iob_ready_o
);

   localparam int MEM_WORDS = 256;

   word_t mem [MEM_WORDS];

   initial begin
      logic [7:0]  rd_idx;
      logic [31:0] rnd;
      int          rd_wait;
      rd_idx       = '0;
      rd_wait      = 0;
      iob_rdata_o  = '0;
      iob_rvalid_o = 1'b0;
      iob_ready_o  = 1'b0;
      // fill pattern from the word index
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = word_t'(i) ^ 32'hA5A5_0000;
      end
      forever begin
         // bus is stable at the falling edge, accept happens at the next rise
         @(negedge clk_i);
         if (!arst_n_i) begin
            rd_wait = 0;
         end else if (iob_valid_i && iob_ready_o) begin
            if (iob_wstrb_i != '0) begin
               // byte lanes under the strobes only
               for (int b = 0; b < 4; b++) begin
                  if (iob_wstrb_i[b]) begin
                     mem[iob_addr_i[9:2]][8*b +: 8] = iob_wdata_i[8*b +: 8];
                  end
               end
            end else begin
               rd_idx  = iob_addr_i[9:2];
               rnd     = $urandom;
               rd_wait = 1 + int'(rnd[1:0]);
            end
         end
         @(posedge clk_i);
         #1;
         // rvalid is a one cycle pulse
         iob_rvalid_o = 1'b0;
         if (rd_wait > 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
               iob_rvalid_o = 1'b1;
               iob_rdata_o  = mem[rd_idx];
            end
         end
         // about one stall cycle in four
         rnd         = $urandom;
         iob_ready_o = (rnd[1:0] != 2'b00);
      end
   end

endmodule

`default_nettype wire

// File: hw/cache_back_end.sv
// back end of the write-through data cache, top level
// shares one native memory bus between the refill and write channels
`timescale 1ns/1ps
`default_nettype none

`include "cache_be_consts.svh"

module cache_back_end
   import cache_be_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,

   // write buffer
   input  logic       write_valid_i,
   input  word_addr_t write_addr_i,
   input  word_t      write_wdata_i,
   input  wstrb_t     write_wstrb_i,
   output logic       write_ready_o,

   // line refill
   input  logic       replace_valid_i,
   input  line_addr_t replace_addr_i,
   output logic       replace_o,
   output logic       read_valid_o,
   output word_off_t  read_addr_o,
   output word_t      read_rdata_o,

   // memory bus
   output logic       iob_valid_o,
   output be_addr_t   iob_addr_o,
   output word_t      iob_wdata_o,
   output wstrb_t     iob_wstrb_o,
   input  word_t      iob_rdata_i,
   input  logic       iob_rvalid_i,
   input  logic       iob_ready_i
);

   be_addr_t rd_addr;
   be_addr_t wr_addr;
   logic     rd_valid;
   logic     wr_valid;
   logic     wr_busy;
   logic     be_wack;
   logic     be_wack_q;
   logic     be_ack;

   // channels never overlap, read wins the mux while it requests
   assign iob_valid_o = rd_valid | wr_valid;
   assign iob_addr_o  = rd_valid ? rd_addr : wr_addr;

   // write accepted on the bus
   assign be_wack = iob_valid_o & iob_ready_i & (iob_wstrb_o != {`CACHE_BE_NBYTES{1'b0}});

   // write ack one cycle after accept
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         be_wack_q <= 1'b0;
      end else begin
         be_wack_q <= be_wack;
      end
   end

   // one ack event per transfer, rvalid for reads
   assign be_ack = iob_rvalid_i | be_wack_q;

   cache_read_channel u_read_channel (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .wr_busy_i      (wr_busy),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_addr_o    (read_addr_o),
      .read_rdata_o   (read_rdata_o),
      .be_addr_o      (rd_addr),
      .be_valid_o     (rd_valid),
      .be_ready_i     (iob_ready_i),
      .be_ack_i       (be_ack),
      .be_rdata_i     (iob_rdata_i)
   );

   cache_write_channel u_write_channel (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .valid_i   (write_valid_i),
      .addr_i    (write_addr_i),
      .wdata_i   (write_wdata_i),
      .wstrb_i   (write_wstrb_i),
      .replace_i (replace_o),
      .ready_o   (write_ready_o),
      .busy_o    (wr_busy),
      .be_addr_o (wr_addr),
      .be_valid_o(wr_valid),
      .be_ready_i(iob_ready_i),
      .be_ack_i  (be_ack),
      .be_wdata_o(iob_wdata_o),
      .be_wstrb_o(iob_wstrb_o)
   );

endmodule

`default_nettype wire

// File: hw/cache_write_channel.sv
// write-through channel of the cache back end
// holds one word write and issues it on the bus, then waits for its ack
`timescale 1ns/1ps
`default_nettype none

`include "cache_be_consts.svh"

module cache_write_channel
   import cache_be_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,

   // write buffer side
   input  logic       valid_i,
   input  word_addr_t addr_i,
   input  word_t      wdata_i,
   input  wstrb_t     wstrb_i,
   // refill in progress
   input  logic       replace_i,
   output logic       ready_o,
   output logic       busy_o,

   // bus side
   output be_addr_t   be_addr_o,
   output logic       be_valid_o,
   input  logic       be_ready_i,
   input  logic       be_ack_i,
   output word_t      be_wdata_o,
   output wstrb_t     be_wstrb_o
);

   wr_state_t  state_q;
   wr_state_t  state_d;
   word_addr_t addr_q;
   word_t      wdata_q;
   wstrb_t     wstrb_q;
   logic       accept;

   // no new write while busy or while a refill owns the bus
   assign ready_o = (state_q == WR_IDLE) & ~replace_i;
   assign accept  = valid_i & ready_o;

   // accept cycle counts as busy so a refill cannot start alongside it
   assign busy_o = (state_q != WR_IDLE) | accept;

   always_comb begin
      state_d = state_q;
      case (state_q)
         WR_IDLE: begin
            if (accept) begin
               state_d = WR_REQ;
            end
         end
         WR_REQ: begin
            if (be_ready_i) begin
               state_d = WR_ACK;
            end
         end
         WR_ACK: begin
            // ack is the bus accept delayed by one cycle
            if (be_ack_i) begin
               state_d = WR_IDLE;
            end
         end
         default: state_d = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= WR_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // holding register, loaded on accept
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
   end

   assign be_valid_o = (state_q == WR_REQ);
   assign be_addr_o  = {addr_q, {`CACHE_BE_BYTE_OFF_W{1'b0}}};
   assign be_wdata_o = wdata_q;
   // strobes only while the write is on the bus, reads see zero
   assign be_wstrb_o = be_valid_o ? wstrb_q : '0;

endmodule

`default_nettype wire

// File: hw/cache_read_channel.sv
// line refill channel of the cache back end
// reads the words of one line in offset order, one request at a time
`timescale 1ns/1ps
`default_nettype none

`include "cache_be_consts.svh"

module cache_read_channel
   import cache_be_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,

   // refill request from the cache controller
   input  logic       replace_valid_i,
   input  line_addr_t replace_addr_i,
   // write channel still owns the bus
   input  logic       wr_busy_i,

   // refill status and returned words to the data memory
   output logic       replace_o,
   output logic       read_valid_o,
   output word_off_t  read_addr_o,
   output word_t      read_rdata_o,

   // bus side
   output be_addr_t   be_addr_o,
   output logic       be_valid_o,
   input  logic       be_ready_i,
   input  logic       be_ack_i,
   input  word_t      be_rdata_i
);

   rd_state_t  state_q;
   rd_state_t  state_d;
   word_off_t  word_cnt_q;
   line_addr_t line_q;
   logic       start;
   logic       last_word;

   // a write in flight or just accepted keeps the refill waiting
   assign start = replace_valid_i & ~wr_busy_i;

   assign last_word = (word_cnt_q == word_off_t'(`CACHE_BE_LINE_WORDS - 1));

   always_comb begin
      state_d = state_q;
      case (state_q)
         RD_IDLE: begin
            if (start) begin
               state_d = RD_REQ;
            end
         end
         RD_REQ: begin
            // request leaves the bus once accepted
            if (be_ready_i) begin
               state_d = RD_WAIT;
            end
         end
         RD_WAIT: begin
            if (be_ack_i) begin
               if (last_word) begin
                  state_d = RD_IDLE;
               end else begin
                  // next word goes out in the following cycle
                  state_d = RD_REQ;
               end
            end
         end
         default: state_d = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= RD_IDLE;
         word_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         // counter starts every line at offset 0
         if (state_q == RD_IDLE) begin
            word_cnt_q <= '0;
         end else if ((state_q == RD_WAIT) && be_ack_i) begin
            word_cnt_q <= word_cnt_q + 1'b1;
         end
      end
   end

   // line address held for the whole refill
   always_ff @(posedge clk_i) begin
      if ((state_q == RD_IDLE) && start) begin
         line_q <= replace_addr_i;
      end
   end

   assign replace_o  = (state_q != RD_IDLE);
   assign be_valid_o = (state_q == RD_REQ);
   assign be_addr_o  = {line_q, word_cnt_q, {`CACHE_BE_BYTE_OFF_W{1'b0}}};

   // returned word passes straight through in the rvalid cycle
   assign read_valid_o = (state_q == RD_WAIT) & be_ack_i;
   assign read_addr_o  = word_cnt_q;
   assign read_rdata_o = be_rdata_i;

endmodule

`default_nettype wire

// File: hw/cache_be_pkg.sv
// shared types of the cache back end
// modules take them with a wildcard import in the module header
`default_nettype none

`include "cache_be_consts.svh"

package cache_be_pkg;

   // address fields
   typedef logic [`CACHE_BE_ADDR_W-1:0]      be_addr_t;
   typedef logic [`CACHE_BE_WORD_ADDR_W-1:0] word_addr_t;
   typedef logic [`CACHE_BE_LINE_ADDR_W-1:0] line_addr_t;
   typedef logic [`CACHE_BE_WORD_OFF_W-1:0]  word_off_t;

   // payload
   typedef logic [`CACHE_BE_DATA_W-1:0] word_t;
   typedef logic [`CACHE_BE_NBYTES-1:0] wstrb_t;

   // channel state machines
   typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT} rd_state_t;
   typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_ACK} wr_state_t;

endpackage

`default_nettype wire

// File: include/cache_be_consts.svh
// widths and line geometry of the cache back end
// included by the package and by every RTL file of the back end
`ifndef CACHE_BE_CONSTS_SVH
`define CACHE_BE_CONSTS_SVH

// byte address on the memory bus
`define CACHE_BE_ADDR_W 24

// data word, same on front end and back end
`define CACHE_BE_DATA_W 32
`define CACHE_BE_NBYTES 4

// byte select bits below a word
`define CACHE_BE_BYTE_OFF_W 2

// word select bits inside a line
`define CACHE_BE_WORD_OFF_W 2

// derived address fields
`define CACHE_BE_WORD_ADDR_W (`CACHE_BE_ADDR_W - `CACHE_BE_BYTE_OFF_W)
`define CACHE_BE_LINE_ADDR_W (`CACHE_BE_WORD_ADDR_W - `CACHE_BE_WORD_OFF_W)

// bus words in one line
`define CACHE_BE_LINE_WORDS (1 << `CACHE_BE_WORD_OFF_W)

`endif
